//--- hw/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Width of every data word, instruction word and program counter
`define CPU_WORD_W 32

// Both memories hold the same number of words
`define CPU_MEM_DEPTH 256

// Address width that matches the memory depth
`define CPU_MEM_AW 8

// General purpose register file size
`define CPU_REG_COUNT 32

// Register index width, as carried in the rs, rt and rd fields
`define CPU_REG_AW 5

`endif

//--- hw/cpu_isa_pkg.sv
`include "cpu_config.svh"

package cpu_isa_pkg;

    // Primary opcodes that the core executes
    // Any other value falls through to a no-op in the execute stage
    typedef enum logic [5:0] {
        op_rtype_arith = 6'd0,
        op_addi        = 6'd1,
        op_and         = 6'd3,
        op_or          = 6'd4,
        op_andi        = 6'd5,
        op_ori         = 6'd6,
        op_shift       = 6'd7,
        op_lw          = 6'd8,
        op_sw          = 6'd9,
        op_beq         = 6'd10,
        op_bne         = 6'd11,
        op_j           = 6'd16,
        op_slt         = 6'd19,
        op_slti        = 6'd20
    } opcode_e;

    // Function codes shared by the arithmetic group and the shift group
    typedef enum logic [5:0] {
        fn_add_sll = 6'd0,
        fn_sub_srl = 6'd1
    } funct_e;

    // R-form view of an instruction word
    // The 16-bit immediate and the 26-bit jump target are low slices of the same word
    typedef struct packed {
        opcode_e                opcode;
        logic [`CPU_REG_AW-1:0] rs;
        logic [`CPU_REG_AW-1:0] rt;
        logic [`CPU_REG_AW-1:0] rd;
        logic [4:0]             shamt;
        funct_e                 funct;
    } instr_t;

endpackage

//--- hw/cpu_pipe_pkg.sv
`include "cpu_config.svh"

package cpu_pipe_pkg;

    // Instruction word as returned by the instruction memory, tagged with its pc
    typedef struct packed {
        logic                   valid;
        logic [`CPU_WORD_W-1:0] pc;
        cpu_isa_pkg::instr_t    instr;
    } fetch_to_decode_t;

    // Operands and decoded fields, all settled before execute sees them
    typedef struct packed {
        logic                   valid;
        logic [`CPU_WORD_W-1:0] pc;
        cpu_isa_pkg::opcode_e   opcode;
        cpu_isa_pkg::funct_e    funct;
        logic [`CPU_WORD_W-1:0] rs_value;
        logic [`CPU_WORD_W-1:0] rt_value;
        logic [`CPU_REG_AW-1:0] dest;
        logic [4:0]             shamt;
        logic [`CPU_WORD_W-1:0] imm_sext;
        logic [`CPU_WORD_W-1:0] imm_zext;
        logic [`CPU_WORD_W-1:0] jump_target;
    } decode_to_execute_t;

    typedef struct packed {
        logic                   valid;
        logic [`CPU_REG_AW-1:0] dest;
        logic [`CPU_WORD_W-1:0] value;
    } writeback_t;

    typedef struct packed {
        logic                   valid;
        logic [`CPU_WORD_W-1:0] next_pc;
    } redirect_t;

    // One record per finished instruction
    typedef struct packed {
        logic                   valid;
        logic [`CPU_WORD_W-1:0] pc;
        logic                   reg_write;
        logic [`CPU_REG_AW-1:0] dest;
        logic [`CPU_WORD_W-1:0] value;
        logic                   mem_write;
        logic [`CPU_MEM_AW-1:0] mem_addr;
        logic [`CPU_WORD_W-1:0] mem_data;
        logic [`CPU_WORD_W-1:0] next_pc;
    } retire_t;

endpackage

//--- hw/word_memory.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module word_memory #(
    parameter int DEPTH = `CPU_MEM_DEPTH,
    localparam int AW = $clog2(DEPTH)
) (
    input  logic                   clk,
    input  logic                   write_en,
    input  logic [AW-1:0]          write_addr,
    input  logic [`CPU_WORD_W-1:0] write_data,
    input  logic                   read_en,
    input  logic [AW-1:0]          read_addr,
    output logic [`CPU_WORD_W-1:0] read_data
);

    logic [`CPU_WORD_W-1:0] mem [DEPTH];

    // One write port and one registered read port
    // read_data holds its value until the next read
    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
        if (read_en) begin
            read_data <= mem[read_addr];
        end
    end

    // The loader and the stages never touch one word from both ports in a cycle
    a_no_read_write_collision: assert property (@(posedge clk)
        !(write_en && read_en && (write_addr == read_addr)));

endmodule

//--- hw/program_loader.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module program_loader (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start_signal,
    input  logic                   add_into,
    input  logic [`CPU_WORD_W-1:0] new_instruction,
    input  logic                   end_signal,
    output logic                   instr_write_en,
    output logic [`CPU_MEM_AW-1:0] instr_write_addr,
    output logic                   data_write_en,
    output logic [`CPU_MEM_AW-1:0] data_write_addr,
    output logic [`CPU_WORD_W-1:0] load_data,
    output logic [`CPU_WORD_W-1:0] instr_count
);

    logic loading;

    // Loading lasts until start_signal rises, and never resumes after the program ends
    assign loading = !start_signal && !end_signal;

    // add_into steers the incoming word to data memory when high
    assign instr_write_en = loading && !add_into;
    assign data_write_en  = loading && add_into;
    assign load_data      = new_instruction;

    // Program words fill upward from 0 and data words fill downward from the top
    always_ff @(posedge clk) begin
        if (reset) begin
            instr_write_addr <= '0;
            data_write_addr  <= '1;
            instr_count      <= '0;
        end else begin
            if (instr_write_en) begin
                instr_write_addr <= instr_write_addr + 1'b1;
                instr_count      <= instr_count + 1'b1;
            end
            if (data_write_en) begin
                data_write_addr <= data_write_addr - 1'b1;
            end
        end
    end

    // More program words than the instruction memory holds would wrap onto address 0
    a_no_instr_wrap: assert property (@(posedge clk) disable iff (reset)
        instr_write_en |-> (instr_count < `CPU_MEM_DEPTH));

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module fetch_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start_signal,
    input  logic [`CPU_WORD_W-1:0]        instr_count,
    input  cpu_pipe_pkg::redirect_t       redirect,
    output logic                          instr_read_en,
    output logic [`CPU_MEM_AW-1:0]        instr_read_addr,
    input  logic [`CPU_WORD_W-1:0]        instr_word,
    output cpu_pipe_pkg::fetch_to_decode_t fetch_out,
    output logic                          end_signal
);

    logic [`CPU_WORD_W-1:0] pc;
    logic                   in_flight;
    logic                   read_pending;
    logic                   idle;

    // Only one instruction is in the machine, so fetch waits for its redirect
    assign idle            = start_signal && !in_flight && !end_signal;
    assign instr_read_en   = idle && (pc != instr_count);
    assign instr_read_addr = pc[`CPU_MEM_AW-1:0];

    // pc is stable until the redirect, so it still names the word coming back
    assign fetch_out = '{
        valid: read_pending,
        pc:    pc,
        instr: cpu_isa_pkg::instr_t'(instr_word)
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            pc           <= '0;
            in_flight    <= 1'b0;
            read_pending <= 1'b0;
            end_signal   <= 1'b0;
        end else begin
            read_pending <= instr_read_en;
            if (instr_read_en) begin
                in_flight <= 1'b1;
            end else if (redirect.valid) begin
                in_flight <= 1'b0;
                pc        <= redirect.next_pc;
            end
            // Reaching the loaded count ends the run instead of issuing
            if (idle && (pc == instr_count)) begin
                end_signal <= 1'b1;
            end
        end
    end

    // A redirect only ever answers the instruction that fetch issued
    a_redirect_owned: assert property (@(posedge clk) disable iff (reset)
        redirect.valid |-> in_flight);

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module decode_stage (
    input  logic                             clk,
    input  logic                             reset,
    input  cpu_pipe_pkg::fetch_to_decode_t   fetch_in,
    input  cpu_pipe_pkg::writeback_t         writeback,
    output cpu_pipe_pkg::decode_to_execute_t decode_out
);

    logic [`CPU_WORD_W-1:0] regs [`CPU_REG_COUNT];
    cpu_isa_pkg::instr_t    instr;
    logic [15:0]            imm;
    logic                   is_rform;

    assign instr = fetch_in.instr;
    assign imm   = fetch_in.instr[15:0];

    // R-form instructions write rd, everything else writes rt
    assign is_rform = (instr.opcode == cpu_isa_pkg::op_rtype_arith)
                   || (instr.opcode == cpu_isa_pkg::op_and)
                   || (instr.opcode == cpu_isa_pkg::op_or)
                   || (instr.opcode == cpu_isa_pkg::op_shift)
                   || (instr.opcode == cpu_isa_pkg::op_slt);

    // Register 0 is cleared by reset and never written, so it always reads zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeback.valid && (writeback.dest != '0)) begin
            regs[writeback.dest] <= writeback.value;
        end
    end

    // Operands are read in the cycle the instruction word arrives
    // The previous writeback has already landed by then
    always_ff @(posedge clk) begin
        if (reset) begin
            decode_out.valid <= 1'b0;
        end else begin
            decode_out.valid <= fetch_in.valid;
            if (fetch_in.valid) begin
                decode_out.pc          <= fetch_in.pc;
                decode_out.opcode      <= instr.opcode;
                decode_out.funct       <= instr.funct;
                decode_out.rs_value    <= regs[instr.rs];
                decode_out.rt_value    <= regs[instr.rt];
                decode_out.dest        <= is_rform ? instr.rd : instr.rt;
                decode_out.shamt       <= instr.shamt;
                decode_out.imm_sext    <= {{(`CPU_WORD_W - 16){imm[15]}}, imm};
                decode_out.imm_zext    <= {{(`CPU_WORD_W - 16){1'b0}}, imm};
                decode_out.jump_target <= {{(`CPU_WORD_W - 26){1'b0}}, fetch_in.instr[25:0]};
            end
        end
    end

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module execute_stage (
    input  logic                             clk,
    input  logic                             reset,
    input  cpu_pipe_pkg::decode_to_execute_t decode_in,
    output logic                             data_write_en,
    output logic                             data_read_en,
    output logic [`CPU_MEM_AW-1:0]           data_addr,
    output logic [`CPU_WORD_W-1:0]           data_write_data,
    input  logic [`CPU_WORD_W-1:0]           data_read_data,
    output cpu_pipe_pkg::writeback_t         writeback,
    output cpu_pipe_pkg::redirect_t          redirect,
    output cpu_pipe_pkg::retire_t            retire
);

    logic [`CPU_WORD_W-1:0] rs_v;
    logic [`CPU_WORD_W-1:0] rt_v;
    logic                   is_load;
    logic                   load_pending;
    cpu_pipe_pkg::retire_t  next_ret;

    assign rs_v    = decode_in.rs_value;
    assign rt_v    = decode_in.rt_value;
    assign is_load = (decode_in.opcode == cpu_isa_pkg::op_lw);

    // Memory accesses go out in the decode_in.valid cycle
    // A store lands on that edge and load data returns one cycle later
    assign data_addr       = rs_v[`CPU_MEM_AW-1:0] + decode_in.imm_sext[`CPU_MEM_AW-1:0];
    assign data_write_data = rt_v;
    assign data_write_en   = decode_in.valid && (decode_in.opcode == cpu_isa_pkg::op_sw);
    assign data_read_en    = decode_in.valid && is_load;

    always_comb begin
        next_ret           = '0;
        next_ret.valid     = !is_load;
        next_ret.pc        = decode_in.pc;
        next_ret.dest      = decode_in.dest;
        next_ret.next_pc   = decode_in.pc + 1'b1;
        next_ret.reg_write = 1'b1;
        case (decode_in.opcode)
            cpu_isa_pkg::op_rtype_arith: begin
                next_ret.reg_write = (decode_in.funct == cpu_isa_pkg::fn_add_sll)
                                  || (decode_in.funct == cpu_isa_pkg::fn_sub_srl);
                next_ret.value = (decode_in.funct == cpu_isa_pkg::fn_sub_srl) ?
                                 rs_v - rt_v : rs_v + rt_v;
            end
            cpu_isa_pkg::op_shift: begin
                next_ret.reg_write = (decode_in.funct == cpu_isa_pkg::fn_add_sll)
                                  || (decode_in.funct == cpu_isa_pkg::fn_sub_srl);
                next_ret.value = (decode_in.funct == cpu_isa_pkg::fn_sub_srl) ?
                                 rt_v >> decode_in.shamt : rt_v << decode_in.shamt;
            end
            cpu_isa_pkg::op_addi: next_ret.value = rs_v + decode_in.imm_sext;
            cpu_isa_pkg::op_and:  next_ret.value = rs_v & rt_v;
            cpu_isa_pkg::op_or:   next_ret.value = rs_v | rt_v;
            cpu_isa_pkg::op_andi: next_ret.value = rs_v & decode_in.imm_zext;
            cpu_isa_pkg::op_ori:  next_ret.value = rs_v | decode_in.imm_zext;
            cpu_isa_pkg::op_slt: begin
                next_ret.value = {{(`CPU_WORD_W - 1){1'b0}}, $signed(rs_v) < $signed(rt_v)};
            end
            cpu_isa_pkg::op_slti: begin
                next_ret.value = {{(`CPU_WORD_W - 1){1'b0}},
                                  $signed(rs_v) < $signed(decode_in.imm_sext)};
            end
            // The loaded word replaces value when it returns
            cpu_isa_pkg::op_lw: next_ret.mem_addr = data_addr;
            cpu_isa_pkg::op_sw: begin
                next_ret.reg_write = 1'b0;
                next_ret.mem_write = 1'b1;
                next_ret.mem_addr  = data_addr;
                next_ret.mem_data  = rt_v;
            end
            cpu_isa_pkg::op_beq, cpu_isa_pkg::op_bne: begin
                next_ret.reg_write = 1'b0;
                if ((rs_v == rt_v) == (decode_in.opcode == cpu_isa_pkg::op_beq)) begin
                    next_ret.next_pc = decode_in.pc + 1'b1 + decode_in.imm_sext;
                end
            end
            cpu_isa_pkg::op_j: begin
                next_ret.reg_write = 1'b0;
                next_ret.next_pc   = decode_in.jump_target;
            end
            default: next_ret.reg_write = 1'b0;
        endcase
        // Nothing is reported as a result unless a register is written
        if (!next_ret.reg_write) begin
            next_ret.value = '0;
        end
    end

    // Everything but lw retires on the edge after decode_in.valid
    // lw waits in load_pending for the registered memory read
    always_ff @(posedge clk) begin
        if (reset) begin
            retire.valid <= 1'b0;
            load_pending <= 1'b0;
        end else begin
            load_pending <= decode_in.valid && is_load;
            if (decode_in.valid) begin
                retire <= next_ret;
            end else begin
                retire.valid <= load_pending;
                if (load_pending) begin
                    retire.value <= data_read_data;
                end
            end
        end
    end

    // Writeback and redirect share the retire cycle
    assign writeback = '{
        valid: retire.valid && retire.reg_write,
        dest:  retire.dest,
        value: retire.value
    };
    assign redirect = '{valid: retire.valid, next_pc: retire.next_pc};

    a_retire_pulse: assert property (@(posedge clk) disable iff (reset)
        retire.valid |=> !retire.valid);

endmodule

//--- hw/cpu_top.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start_signal,
    input  logic                   add_into,
    input  logic [`CPU_WORD_W-1:0] new_instruction,
    output logic                   end_signal,
    output cpu_pipe_pkg::retire_t  retire
);

    logic                   imem_write_en;
    logic [`CPU_MEM_AW-1:0] imem_write_addr;
    logic                   imem_read_en;
    logic [`CPU_MEM_AW-1:0] imem_read_addr;
    logic [`CPU_WORD_W-1:0] imem_read_data;
    logic                   load_data_en;
    logic [`CPU_MEM_AW-1:0] load_data_addr;
    logic [`CPU_WORD_W-1:0] load_data;
    logic [`CPU_WORD_W-1:0] instr_count;
    logic                   exec_write_en;
    logic                   exec_read_en;
    logic [`CPU_MEM_AW-1:0] exec_addr;
    logic [`CPU_WORD_W-1:0] exec_write_data;
    logic [`CPU_WORD_W-1:0] dmem_read_data;

    cpu_pipe_pkg::fetch_to_decode_t   fetch_to_decode;
    cpu_pipe_pkg::decode_to_execute_t decode_to_execute;
    cpu_pipe_pkg::writeback_t         writeback;
    cpu_pipe_pkg::redirect_t          redirect;

    program_loader i_loader (
        .clk              (clk),
        .reset            (reset),
        .start_signal     (start_signal),
        .add_into         (add_into),
        .new_instruction  (new_instruction),
        .end_signal       (end_signal),
        .instr_write_en   (imem_write_en),
        .instr_write_addr (imem_write_addr),
        .data_write_en    (load_data_en),
        .data_write_addr  (load_data_addr),
        .load_data        (load_data),
        .instr_count      (instr_count)
    );

    word_memory i_instr_mem (
        .clk        (clk),
        .write_en   (imem_write_en),
        .write_addr (imem_write_addr),
        .write_data (load_data),
        .read_en    (imem_read_en),
        .read_addr  (imem_read_addr),
        .read_data  (imem_read_data)
    );

    // Data memory is owned by the loader before start and by execute after it
    word_memory i_data_mem (
        .clk        (clk),
        .write_en   (start_signal ? exec_write_en : load_data_en),
        .write_addr (start_signal ? exec_addr : load_data_addr),
        .write_data (start_signal ? exec_write_data : load_data),
        .read_en    (exec_read_en),
        .read_addr  (exec_addr),
        .read_data  (dmem_read_data)
    );

    fetch_stage i_fetch (
        .clk             (clk),
        .reset           (reset),
        .start_signal    (start_signal),
        .instr_count     (instr_count),
        .redirect        (redirect),
        .instr_read_en   (imem_read_en),
        .instr_read_addr (imem_read_addr),
        .instr_word      (imem_read_data),
        .fetch_out       (fetch_to_decode),
        .end_signal      (end_signal)
    );

    decode_stage i_decode (
        .clk        (clk),
        .reset      (reset),
        .fetch_in   (fetch_to_decode),
        .writeback  (writeback),
        .decode_out (decode_to_execute)
    );

    execute_stage i_execute (
        .clk             (clk),
        .reset           (reset),
        .decode_in       (decode_to_execute),
        .data_write_en   (exec_write_en),
        .data_read_en    (exec_read_en),
        .data_addr       (exec_addr),
        .data_write_data (exec_write_data),
        .data_read_data  (dmem_read_data),
        .writeback       (writeback),
        .redirect        (redirect),
        .retire          (retire)
    );

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int period_ns = 4
) (
    output logic clk
);

    // Free-running clock that starts low, so the first edge is a rising one
    initial begin
        clk = 1'b0;
    end

    always #(period_ns / 2) clk = ~clk;

endmodule

//--- verification/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb;

    // Opcodes of the kept instructions, as listed in the instruction set table
    localparam logic [5:0] op_arith = 6'd0;
    localparam logic [5:0] op_addi  = 6'd1;
    localparam logic [5:0] op_and   = 6'd3;
    localparam logic [5:0] op_or    = 6'd4;
    localparam logic [5:0] op_andi  = 6'd5;
    localparam logic [5:0] op_ori   = 6'd6;
    localparam logic [5:0] op_shift = 6'd7;
    localparam logic [5:0] op_lw    = 6'd8;
    localparam logic [5:0] op_sw    = 6'd9;
    localparam logic [5:0] op_beq   = 6'd10;
    localparam logic [5:0] op_bne   = 6'd11;
    localparam logic [5:0] op_j     = 6'd16;
    localparam logic [5:0] op_slt   = 6'd19;
    localparam logic [5:0] op_slti  = 6'd20;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 4;
    localparam int num_programs = 5;
    localparam int min_instr    = 24;
    localparam int max_instr    = 40;
    localparam int min_data     = 8;
    localparam int max_data     = 16;
    localparam int tail_cycles  = 6;

    // Loads and stores address data memory through r31, which no generated instruction writes
    localparam logic [4:0] base_reg = 5'd31;

    // Worst case per program is 6 cycles per instruction plus reset, load and the tail
    localparam int program_cycles = reset_cycles + 1 + max_instr + max_data
                                  + 6 * max_instr + tail_cycles;
    localparam int watchdog_ns = num_programs * program_cycles * clk_period;

    logic                  clk;
    logic                  reset;
    logic                  start_signal;
    logic                  add_into;
    logic [31:0]           new_instruction;
    logic                  end_signal;
    cpu_pipe_pkg::retire_t retire;

    integer seed = 81;

    // Current program and its data words, in load order
    logic [31:0] prog [256];
    logic [31:0] data_words [256];
    int          n_instr;
    int          n_data;

    // Reference model state
    logic [31:0] m_regs [32];
    logic [31:0] m_dmem [256];
    logic [31:0] m_pc;

    tb_clock_gen #(.period_ns(clk_period)) i_clock (.clk(clk));

    cpu_top i_dut (
        .clk             (clk),
        .reset           (reset),
        .start_signal    (start_signal),
        .add_into        (add_into),
        .new_instruction (new_instruction),
        .end_signal      (end_signal),
        .retire          (retire)
    );

    // Uniform integer in [lo, hi], drawn from the seeded generator
    function automatic int pick(int lo, int hi);
        int r;
        r = $random(seed) & 32'h7fffffff;
        return lo + r % (hi - lo + 1);
    endfunction

    function automatic logic [31:0] encode_r(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                             logic [4:0] rd, logic [4:0] shamt, logic [5:0] fn);
        return {op, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] encode_i(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                             logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s: got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Builds a random program whose branches and jumps only point forward
    task automatic build_program();
        int          kind;
        int          i;
        int          k;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        n_instr = pick(min_instr, max_instr);
        n_data  = pick(min_data, max_data);
        for (k = 0; k < n_data; k++) begin
            data_words[k] = $random(seed);
        end
        // The first instruction points r31 at the lowest loaded data word
        prog[0] = encode_i(op_addi, 5'd0, base_reg, 16'(256 - n_data));
        for (i = 1; i < n_instr; i++) begin
            rs   = 5'(pick(0, 31));
            rt   = 5'(pick(0, 31));
            // Destinations stay below r31 so the base register survives
            rd   = 5'(pick(0, 30));
            kind = pick(0, 15);
            case (kind)
                0: prog[i] = encode_r(op_arith, rs, rt, rd, 5'd0, 6'd0);
                1: prog[i] = encode_r(op_arith, rs, rt, rd, 5'd0, 6'd1);
                2: prog[i] = encode_r(op_and, rs, rt, rd, 5'd0, 6'd0);
                3: prog[i] = encode_r(op_or, rs, rt, rd, 5'd0, 6'd0);
                4: prog[i] = encode_r(op_slt, rs, rt, rd, 5'd0, 6'd0);
                5: prog[i] = encode_r(op_shift, rs, rt, rd, 5'(pick(0, 31)), 6'd0);
                6: prog[i] = encode_r(op_shift, rs, rt, rd, 5'(pick(0, 31)), 6'd1);
                7: prog[i] = encode_i(op_addi, rs, rd, 16'(pick(-16, 15)));
                8: prog[i] = encode_i(op_andi, rs, rd, 16'(pick(0, 255)));
                9: prog[i] = encode_i(op_ori, rs, rd, 16'(pick(0, 255)));
                10: prog[i] = encode_i(op_slti, rs, rd, 16'(pick(-16, 15)));
                11: prog[i] = encode_i(op_lw, base_reg, rd, 16'(pick(0, n_data - 1)));
                12: prog[i] = encode_i(op_sw, base_reg, rt, 16'(pick(0, n_data - 1)));
                13, 14: begin
                    // Comparing a register with itself makes sure some branches are taken
                    if (pick(0, 2) == 0) begin
                        rt = rs;
                    end
                    prog[i] = encode_i((kind == 13) ? op_beq : op_bne, rs, rt,
                                       16'(pick(0, n_instr - 1 - i)));
                end
                default: prog[i] = {op_j, 26'(pick(i + 1, n_instr))};
            endcase
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset           = 1'b1;
        start_signal    = 1'b0;
        add_into        = 1'b0;
        new_instruction = '0;
        repeat (reset_cycles) @(negedge clk);
        check_value("end_signal during reset", 32'(end_signal), 32'd0);
        check_value("retire.valid during reset", 32'(retire.valid), 32'd0);
        reset = 1'b0;
    endtask

    // Interleaves instruction and data words at random, one word per cycle
    task automatic load_program();
        int i_idx;
        int d_idx;
        i_idx = 0;
        d_idx = 0;
        while ((i_idx < n_instr) || (d_idx < n_data)) begin
            if ((i_idx < n_instr) && ((d_idx >= n_data) || (pick(0, 1) == 0))) begin
                add_into        = 1'b0;
                new_instruction = prog[i_idx];
                i_idx++;
            end else begin
                add_into        = 1'b1;
                new_instruction = data_words[d_idx];
                d_idx++;
            end
            @(negedge clk);
        end
        add_into        = 1'b0;
        new_instruction = '0;
        start_signal    = 1'b1;
    endtask

    // Predicts the retire record of the instruction at the model pc, checks it, then commits
    task automatic compare_retire();
        logic [31:0] word;
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        logic        rform;
        logic        exp_reg_write;
        logic        exp_mem_write;
        logic [4:0]  exp_dest;
        logic [31:0] exp_value;
        logic [7:0]  exp_mem_addr;
        logic [31:0] exp_mem_data;
        logic [31:0] exp_next_pc;
        string       where;
        where = $sformatf("retire at pc %0d", m_pc);
        check_value({where, " beyond the last instruction"},
                    32'(m_pc >= 32'(n_instr)), 32'd0);
        check_value({where, " pc"}, retire.pc, m_pc);
        word  = prog[m_pc[7:0]];
        op    = word[31:26];
        rs    = word[25:21];
        rt    = word[20:16];
        rd    = word[15:11];
        shamt = word[10:6];
        a     = m_regs[rs];
        b     = m_regs[rt];
        sext  = {{16{word[15]}}, word[15:0]};
        zext  = {16'd0, word[15:0]};
        rform = (op == op_arith) || (op == op_and) || (op == op_or)
             || (op == op_shift) || (op == op_slt);
        exp_dest      = rform ? rd : rt;
        exp_reg_write = 1'b1;
        exp_mem_write = 1'b0;
        exp_value     = '0;
        exp_mem_addr  = '0;
        exp_mem_data  = '0;
        exp_next_pc   = m_pc + 32'd1;
        case (op)
            op_arith: exp_value = (word[5:0] == 6'd1) ? a - b : a + b;
            op_shift: exp_value = (word[5:0] == 6'd1) ? b >> shamt : b << shamt;
            op_addi:  exp_value = a + sext;
            op_and:   exp_value = a & b;
            op_or:    exp_value = a | b;
            op_andi:  exp_value = a & zext;
            op_ori:   exp_value = a | zext;
            op_slt:   exp_value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_slti:  exp_value = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            op_lw: begin
                exp_mem_addr = a[7:0] + word[7:0];
                exp_value    = m_dmem[exp_mem_addr];
            end
            op_sw: begin
                exp_reg_write = 1'b0;
                exp_mem_write = 1'b1;
                exp_mem_addr  = a[7:0] + word[7:0];
                exp_mem_data  = b;
            end
            op_beq, op_bne: begin
                exp_reg_write = 1'b0;
                if ((a == b) == (op == op_beq)) begin
                    exp_next_pc = m_pc + 32'd1 + sext;
                end
            end
            op_j: begin
                exp_reg_write = 1'b0;
                exp_next_pc   = {6'd0, word[25:0]};
            end
            default: exp_reg_write = 1'b0;
        endcase
        check_value({where, " reg_write"}, 32'(retire.reg_write), 32'(exp_reg_write));
        check_value({where, " dest"}, 32'(retire.dest), 32'(exp_dest));
        check_value({where, " value"}, retire.value, exp_value);
        check_value({where, " mem_write"}, 32'(retire.mem_write), 32'(exp_mem_write));
        check_value({where, " mem_addr"}, 32'(retire.mem_addr), 32'(exp_mem_addr));
        check_value({where, " mem_data"}, retire.mem_data, exp_mem_data);
        check_value({where, " next_pc"}, retire.next_pc, exp_next_pc);
        // Register 0 takes the write in the record but keeps reading zero
        if (exp_reg_write && (exp_dest != 5'd0)) begin
            m_regs[exp_dest] = exp_value;
        end
        if (exp_mem_write) begin
            m_dmem[exp_mem_addr] = exp_mem_data;
        end
        m_pc = exp_next_pc;
    endtask

    task automatic run_program(input int index);
        int k;
        int retired;
        bit done;
        build_program();
        apply_reset();
        for (k = 0; k < 32; k++) begin
            m_regs[k] = '0;
        end
        // The k-th data word loaded lands at 255 - k
        for (k = 0; k < n_data; k++) begin
            m_dmem[8'(255 - k)] = data_words[k];
        end
        m_pc = '0;
        load_program();
        retired = 0;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (retire.valid) begin
                compare_retire();
                retired++;
            end else if (end_signal) begin
                check_value("model pc when end_signal rises", m_pc, 32'(n_instr));
                done = 1'b1;
            end
        end
        // The core stays finished and silent until the next reset
        repeat (tail_cycles) begin
            @(negedge clk);
            check_value("retire.valid after end_signal", 32'(retire.valid), 32'd0);
            check_value("end_signal held after the end", 32'(end_signal), 32'd1);
        end
        $display("Program %0d: %0d instructions, %0d data words, %0d retired",
                 index, n_instr, n_data, retired);
    endtask

    initial begin
        reset           = 1'b1;
        start_signal    = 1'b0;
        add_into        = 1'b0;
        new_instruction = '0;
        for (int p = 0; p < num_programs; p++) begin
            run_program(p);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // Ends a run that hangs, for example when end_signal never rises
    initial begin
        #(watchdog_ns);
        $display("The processor did not finish its programs within %0d ns", watchdog_ns);
        $display("CHECKS FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- build.f
+incdir+hw
hw/cpu_isa_pkg.sv
hw/cpu_pipe_pkg.sv
hw/word_memory.sv
hw/program_loader.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/cpu_top.sv
verification/tb_clock_gen.sv
verification/cpu_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module cpu_tb \
		-Mdir obj_dir -o cpu_sim
	-./obj_dir/cpu_sim 2>&1 | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module cpu_top

clean:
	rm -rf obj_dir $(LOG)
